// ==== verilog/fifo_config.svh ====
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// Width of one stored word
`define FIFO_DW 32

// Address bits into the storage array
`define FIFO_AW 3

// Entry count follows from the address width
`define FIFO_DEPTH (1 << `FIFO_AW)

// Programmable-full level out of reset
`define FIFO_PROG_FULL_DEFAULT 6

`endif

// ==== verilog/fifo_pkg.sv ====
package fifo_pkg;

`include "fifo_config.svh"

  // One FIFO word
  typedef logic [`FIFO_DW-1:0] data_t;

  // Storage address
  typedef logic [`FIFO_AW-1:0] addr_t;

  // Pointer with wrap bit
  // Binary or Gray coded, also threshold and occupancy width
  typedef logic [`FIFO_AW:0] ptr_t;

endpackage

// ==== verilog/memory_dp.sv ====
module memory_dp
  import fifo_pkg::*;
#(
  parameter int DW = $bits(data_t),
  parameter int AW = $bits(addr_t)
) (
  // Write port
  input  logic  wr_clk,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  data_t wr_data,
  // Read port
  input  logic  rd_clk,
  input  addr_t rd_addr,
  output data_t rd_data
);

  // Storage array, no reset
  logic [DW-1:0] mem [0:(1 << AW)-1];

  // Write side
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read side
  // Sampled on every edge, gives the FWFT head with a look-ahead address
  always_ff @(posedge rd_clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== verilog/synchronizer.sv ====
module synchronizer #(
  parameter int DW = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [DW-1:0] in,
  output logic [DW-1:0] out
);

  // First stage, may go metastable
  logic [DW-1:0] sync_meta;

  // Two flops in the destination domain
  // Only Gray values pass here, so one bit moves at a time
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_meta <= '0;
      out       <= '0;
    end else begin
      sync_meta <= in;
      out       <= sync_meta;
    end
  end

endmodule

// ==== verilog/fifo_full_block.sv ====
module fifo_full_block
  import fifo_pkg::*;
(
  input  logic  wr_clk,
  input  logic  rst_n,
  // Write request from the producer
  input  logic  wr_write,
  // Read pointer after the synchronizer
  input  ptr_t  wr_rd_gray_pointer,
  input  ptr_t  prog_threshold,
  // Storage write controls
  output logic  wr_push,
  output addr_t wr_addr,
  output ptr_t  wr_gray_pointer,
  // Flags
  output logic  wr_fifo_full,
  output logic  wr_fifo_progfull
);

  localparam int AW = $bits(addr_t);

  ptr_t wr_binary_pointer;
  ptr_t wr_binary_next;
  ptr_t wr_gray_next;
  ptr_t wr_rd_binary_pointer;
  ptr_t wr_count_next;
  logic wr_full_next;

  // ####################
  // Pointer advance
  // ####################

  // Writes while full are dropped here and nowhere else
  assign wr_push = wr_write & ~wr_fifo_full;

  assign wr_binary_next = wr_binary_pointer + ptr_t'(wr_push);
  assign wr_gray_next   = (wr_binary_next >> 1) ^ wr_binary_next;

  // Current slot, written on the same edge the pointer moves
  assign wr_addr = wr_binary_pointer[AW-1:0];

  // ####################
  // Occupancy
  // ####################

  // Gray to binary on the synchronized read pointer
  always_comb begin
    wr_rd_binary_pointer[AW] = wr_rd_gray_pointer[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      wr_rd_binary_pointer[i] = wr_rd_binary_pointer[i+1] ^ wr_rd_gray_pointer[i];
    end
  end

  // Modulo subtraction, wrap bit keeps 0 and DEPTH apart
  assign wr_count_next = wr_binary_next - wr_rd_binary_pointer;

  // Full when writer is one lap ahead
  // Top two Gray bits differ, the rest match
  assign wr_full_next = (wr_gray_next == {~wr_rd_gray_pointer[AW:AW-1],
                                          wr_rd_gray_pointer[AW-2:0]});

  // ####################
  // State
  // ####################

  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_binary_pointer <= '0;
      wr_gray_pointer   <= '0;
      wr_fifo_full      <= 1'b0;
      wr_fifo_progfull  <= 1'b0;
    end else begin
      wr_binary_pointer <= wr_binary_next;
      wr_gray_pointer   <= wr_gray_next;
      wr_fifo_full      <= wr_full_next;
      // Level compare on next occupancy
      wr_fifo_progfull  <= (wr_count_next >= prog_threshold);
    end
  end

endmodule

// ==== verilog/fifo_empty_block.sv ====
module fifo_empty_block
  import fifo_pkg::*;
(
  input  logic  rd_clk,
  input  logic  rst_n,
  // Pop request from the consumer
  input  logic  rd_read,
  // Write pointer after the synchronizer
  input  ptr_t  rd_wr_gray_pointer,
  output addr_t rd_addr,
  output ptr_t  rd_gray_pointer,
  output logic  rd_fifo_empty
);

  localparam int AW = $bits(addr_t);

  ptr_t rd_binary_pointer;
  ptr_t rd_binary_next;
  ptr_t rd_gray_next;
  logic rd_pop;

  // Pops on empty are ignored
  assign rd_pop = rd_read & ~rd_fifo_empty;

  assign rd_binary_next = rd_binary_pointer + ptr_t'(rd_pop);
  assign rd_gray_next   = (rd_binary_next >> 1) ^ rd_binary_next;

  // Look-ahead address
  // Storage registers this, so dout is the new head as the pointer moves
  assign rd_addr = rd_binary_next[AW-1:0];

  // ####################
  // Pointer and flag
  // ####################

  always_ff @(posedge rd_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_binary_pointer <= '0;
      rd_gray_pointer   <= '0;
      // Nothing stored out of reset
      rd_fifo_empty     <= 1'b1;
    end else begin
      rd_binary_pointer <= rd_binary_next;
      rd_gray_pointer   <= rd_gray_next;
      // Caught up with the writer
      rd_fifo_empty     <= (rd_gray_next == rd_wr_gray_pointer);
    end
  end

endmodule

// ==== verilog/fifo_threshold_reg.sv ====
`include "fifo_config.svh"

module fifo_threshold_reg
  import fifo_pkg::*;
(
  input  logic wr_clk,
  input  logic rst_n,
  // Config load strobe and value
  input  logic cfg_wr,
  input  ptr_t cfg_threshold,
  output ptr_t prog_threshold
);

  ptr_t threshold_clamped;

  // Clamp to 1 .. DEPTH
  always_comb begin
    if (cfg_threshold == '0) begin
      threshold_clamped = ptr_t'(1);
    end else if (cfg_threshold > ptr_t'(`FIFO_DEPTH)) begin
      threshold_clamped = ptr_t'(`FIFO_DEPTH);
    end else begin
      threshold_clamped = cfg_threshold;
    end
  end

  // Write-domain level register
  always_ff @(posedge wr_clk or negedge rst_n) begin
    if (!rst_n) begin
      prog_threshold <= ptr_t'(`FIFO_PROG_FULL_DEFAULT);
    end else if (cfg_wr) begin
      prog_threshold <= threshold_clamped;
    end
  end

endmodule

// ==== verilog/fifo_async.sv ====
module fifo_async
  import fifo_pkg::*;
(
  // Clocks and reset
  input  logic  wr_clk,
  input  logic  rd_clk,
  input  logic  rst_n,
  // Write side
  input  logic  wr_en,
  input  data_t din,
  input  logic  cfg_wr,
  input  ptr_t  cfg_threshold,
  output logic  full,
  output logic  prog_full,
  // Read side
  input  logic  rd_en,
  output data_t dout,
  output logic  empty
);

  logic  wr_push;
  addr_t wr_addr;
  addr_t rd_addr;
  ptr_t  wr_gray_pointer;
  ptr_t  rd_gray_pointer;
  ptr_t  wr_rd_gray_pointer;
  ptr_t  rd_wr_gray_pointer;
  ptr_t  prog_threshold;

  // ####################
  // Storage
  // ####################

  memory_dp #(
    .DW($bits(data_t)),
    .AW($bits(addr_t))
  ) memory_dp (
    .wr_clk  (wr_clk),
    .wr_en   (wr_push),
    .wr_addr (wr_addr),
    .wr_data (din),
    .rd_clk  (rd_clk),
    .rd_addr (rd_addr),
    .rd_data (dout)
  );

  // ####################
  // Write domain
  // ####################

  fifo_threshold_reg fifo_threshold_reg (
    .wr_clk         (wr_clk),
    .rst_n          (rst_n),
    .cfg_wr         (cfg_wr),
    .cfg_threshold  (cfg_threshold),
    .prog_threshold (prog_threshold)
  );

  fifo_full_block fifo_full_block (
    .wr_clk             (wr_clk),
    .rst_n              (rst_n),
    .wr_write           (wr_en),
    .wr_rd_gray_pointer (wr_rd_gray_pointer),
    .prog_threshold     (prog_threshold),
    .wr_push            (wr_push),
    .wr_addr            (wr_addr),
    .wr_gray_pointer    (wr_gray_pointer),
    .wr_fifo_full       (full),
    .wr_fifo_progfull   (prog_full)
  );

  // Read pointer into wr_clk
  synchronizer #(.DW($bits(ptr_t))) rd2wr_sync (
    .clk   (wr_clk),
    .rst_n (rst_n),
    .in    (rd_gray_pointer),
    .out   (wr_rd_gray_pointer)
  );

  // ####################
  // Read domain
  // ####################

  fifo_empty_block fifo_empty_block (
    .rd_clk             (rd_clk),
    .rst_n              (rst_n),
    .rd_read            (rd_en),
    .rd_wr_gray_pointer (rd_wr_gray_pointer),
    .rd_addr            (rd_addr),
    .rd_gray_pointer    (rd_gray_pointer),
    .rd_fifo_empty      (empty)
  );

  // Write pointer into rd_clk
  synchronizer #(.DW($bits(ptr_t))) wr2rd_sync (
    .clk   (rd_clk),
    .rst_n (rst_n),
    .in    (wr_gray_pointer),
    .out   (rd_wr_gray_pointer)
  );

endmodule

// ==== verification/fifo_async_checker.sv ====
module fifo_async_checker
  import fifo_pkg::*;
(
  input logic wr_clk,
  input logic rd_clk,
  input logic rst_n,
  input logic full,
  input logic empty,
  input ptr_t wr_gray_pointer,
  input ptr_t rd_gray_pointer
);

  // Failed assertions so far
  int failure_count = 0;

  // Flags exclude each other
  full_not_empty: assert property (@(posedge wr_clk) disable iff (!rst_n)
    !(full && empty))
    else begin
      failure_count++;
      $error("full and empty are high together");
    end

  // ####################
  // Gray pointers
  // ####################

  // Write pointer, one bit per wr_clk edge at most
  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!rst_n)
    $countones(wr_gray_pointer ^ $past(wr_gray_pointer)) <= 1)
    else begin
      failure_count++;
      $error("write Gray pointer changed more than one bit");
    end

  // Same for the read pointer
  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!rst_n)
    $countones(rd_gray_pointer ^ $past(rd_gray_pointer)) <= 1)
    else begin
      failure_count++;
      $error("read Gray pointer changed more than one bit");
    end

  // Nothing stored right after reset release
  empty_after_reset: assert property (@(posedge rd_clk) $rose(rst_n) |-> empty)
    else begin
      failure_count++;
      $error("empty is low in the first rd_clk cycle after reset");
    end

endmodule

bind fifo_async fifo_async_checker flag_checker (
  .wr_clk          (wr_clk),
  .rd_clk          (rd_clk),
  .rst_n           (rst_n),
  .full            (full),
  .empty           (empty),
  .wr_gray_pointer (wr_gray_pointer),
  .rd_gray_pointer (rd_gray_pointer)
);

// ==== verification/fifo_async_tb.sv ====
`include "fifo_config.svh"

module fifo_async_tb
  import fifo_pkg::*;
;

  logic  wr_clk = 1'b0;
  logic  rd_clk = 1'b0;
  logic  rst_n;
  logic  wr_en;
  data_t din;
  logic  cfg_wr;
  ptr_t  cfg_threshold;
  logic  full;
  logic  prog_full;
  logic  rd_en;
  data_t dout;
  logic  empty;

  // Scoreboard of accepted writes
  data_t sb[$];
  data_t head_word;
  int    write_total = 0;
  int    read_total = 0;
  string cur_name = "reset";

  // Test phases from the stimulus file
  string phase_name[$];
  int    phase_words[$];
  int    phase_mode[$];
  int    phase_threshold[$];
  int    phase_prog_full[$];
  int    phase_full[$];
  logic  stimulus_loaded = 1'b0;
  longint watchdog_limit;

  // Asynchronous clocks
  always #4 wr_clk = ~wr_clk;
  always #7 rd_clk = ~rd_clk;

  fifo_async DUT (
    .wr_clk        (wr_clk),
    .rd_clk        (rd_clk),
    .rst_n         (rst_n),
    .wr_en         (wr_en),
    .din           (din),
    .cfg_wr        (cfg_wr),
    .cfg_threshold (cfg_threshold),
    .full          (full),
    .prog_full     (prog_full),
    .rd_en         (rd_en),
    .dout          (dout),
    .empty         (empty)
  );

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(string what, int expected, int actual);
    assert (expected == actual) else begin
      $display("CHECK FAILED %s %s expected %0d actual %0d", cur_name, what, expected, actual);
      abort_run();
    end
  endtask

  // ####################
  // Monitors
  // ####################

  // Accepted write as sampled at the edge
  always @(posedge wr_clk) begin
    if (rst_n && wr_en && !full) begin
      sb.push_back(din);
      write_total++;
    end
  end

  // Accepted read pops the head and compares it with the FWFT word on dout
  always @(posedge rd_clk) begin
    if (rst_n && rd_en && !empty) begin
      if (sb.size() == 0) begin
        $display("A read was accepted while the scoreboard held no word");
        abort_run();
      end else begin
        head_word = sb.pop_front();
        assert (dout === head_word) else begin
          $display("CHECK FAILED %s expected %h actual %h", cur_name, head_word, dout);
          abort_run();
        end
        read_total++;
      end
    end
  end

  // Bound checker failures end the run too
  always @(posedge rd_clk) begin
    if (DUT.flag_checker.failure_count != 0) begin
      $display("An assertion in the bound flag checker failed");
      abort_run();
    end
  end

  // ####################
  // Phase tasks
  // ####################

  task automatic load_stimulus();
    int fd;
    int got;
    int words, mode, thr, exp_pf, exp_full;
    string line;
    string nm;
    longint total;
    fd = $fopen("verification/fifo_async_stimulus.txt", "r");
    if (fd == 0) begin
      $display("The stimulus file could not be opened");
      abort_run();
    end
    total = 0;
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      // Skip comments and blank lines
      if (line.len() > 0 && line.getc(0) != "#") begin
        got = $sscanf(line, "%s %d %d %d %d %d", nm, words, mode, thr, exp_pf, exp_full);
        if (got == 6) begin
          phase_name.push_back(nm);
          phase_words.push_back(words);
          phase_mode.push_back(mode);
          phase_threshold.push_back(thr);
          phase_prog_full.push_back(exp_pf);
          phase_full.push_back(exp_full);
          total += words;
        end
      end
    end
    $fclose(fd);
    if (phase_name.size() == 0) begin
      $display("The stimulus file holds no test phases");
      abort_run();
    end
    // 20 rd_clk periods per word plus 200
    watchdog_limit = (total * 20 + 200) * 14;
  endtask

  task automatic load_threshold(int thr);
    @(posedge wr_clk);
    #1;
    cfg_threshold = ptr_t'(thr);
    cfg_wr = 1'b1;
    @(posedge wr_clk);
    #1;
    cfg_wr = 1'b0;
  endtask

  // Reader on until the scoreboard is empty
  task automatic drain_all();
    @(posedge rd_clk);
    #1;
    rd_en = 1'b1;
    while (sb.size() != 0) begin
      @(posedge rd_clk);
      #1;
    end
    rd_en = 1'b0;
    @(posedge rd_clk);
    #1;
    check_value("empty after drain", 1, empty);
    // Let the read pointer reach the write side
    repeat (6) @(posedge wr_clk);
  endtask

  task automatic run_stall(int words, int exp_pf, int exp_full);
    int start;
    start = write_total;
    @(posedge wr_clk);
    #1;
    // Threshold is at least 1, so an empty FIFO sits below it
    check_value("prog_full before writes", 0, prog_full);
    for (int i = 0; i < words; i++) begin
      din = data_t'(write_total);
      wr_en = 1'b1;
      @(posedge wr_clk);
      #1;
    end
    wr_en = 1'b0;
    repeat (4) @(posedge wr_clk);
    #1;
    check_value("prog_full", exp_pf, prog_full);
    check_value("full", exp_full, full);
    // Writes past depth are dropped
    check_value("accepted words", (words > `FIFO_DEPTH) ? `FIFO_DEPTH : words,
                write_total - start);
    drain_all();
  endtask

  task automatic run_random(int words);
    int wstart;
    int rstart;
    wstart = write_total;
    rstart = read_total;
    fork
      begin
        @(posedge wr_clk);
        #1;
        while (write_total - wstart < words) begin
          din = data_t'(write_total);
          wr_en = ($urandom % 4) != 0;
          @(posedge wr_clk);
          #1;
        end
        wr_en = 1'b0;
      end
      begin
        @(posedge rd_clk);
        #1;
        while (read_total - rstart < words) begin
          rd_en = ($urandom % 3) != 0;
          @(posedge rd_clk);
          #1;
        end
        rd_en = 1'b0;
      end
    join
    @(posedge rd_clk);
    #1;
    check_value("empty after traffic", 1, empty);
    repeat (6) @(posedge wr_clk);
  endtask

  // ####################
  // Main sequence
  // ####################

  initial begin
    void'($urandom(34));
    rst_n = 1'b0;
    wr_en = 1'b0;
    din = '0;
    cfg_wr = 1'b0;
    cfg_threshold = '0;
    rd_en = 1'b0;
    load_stimulus();
    stimulus_loaded = 1'b1;
    repeat (3) @(posedge wr_clk);
    #1;
    rst_n = 1'b1;
    // Flags out of reset
    @(posedge wr_clk);
    #1;
    check_value("empty", 1, empty);
    check_value("full", 0, full);
    check_value("prog_full", 0, prog_full);
    for (int p = 0; p < phase_name.size(); p++) begin
      cur_name = phase_name[p];
      if (phase_threshold[p] >= 0) begin
        load_threshold(phase_threshold[p]);
      end
      if (phase_mode[p] == 0) begin
        run_stall(phase_words[p], phase_prog_full[p], phase_full[p]);
      end else begin
        run_random(phase_words[p]);
      end
    end
    if (sb.size() == 0 && DUT.flag_checker.failure_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("Words were left in the scoreboard or a checker assertion failed");
      abort_run();
    end
  end

  // Watchdog sized from the total word count
  initial begin
    wait (stimulus_loaded);
    #(watchdog_limit);
    $display("Timeout, the run did not finish within %0d time units", watchdog_limit);
    abort_run();
  end

endmodule

// ==== fifo_async.f ====
+incdir+verilog
verilog/fifo_pkg.sv
verilog/memory_dp.sv
verilog/synchronizer.sv
verilog/fifo_full_block.sv
verilog/fifo_empty_block.sv
verilog/fifo_threshold_reg.sv
verilog/fifo_async.sv
verification/fifo_async_checker.sv
verification/fifo_async_tb.sv

// ==== verification/fifo_async_stimulus.txt ====
# Columns: name words mode threshold exp_prog_full exp_full
# Mode 0 holds the reader off until all writes are issued, mode 1 runs both sides at random rates
# Threshold -1 keeps the current level, expected flags are checked only in mode 0

# Two words past depth, both dropped
overflow        10  0  -1  1  1

# Default level of 6
below_level      5  0  -1  0  0
at_level         6  0  -1  1  0

# Level loaded through cfg_wr
level_three      3  0   3  1  0
under_three      2  0   3  0  0

# Zero clamps to 1
level_zero       1  0   0  1  0

# Oversize clamps to depth
level_big        8  0  15  1  1
level_big_low    7  0  15  0  0

# Both sides at random rates
random_default 400  1   6  0  0
random_low     150  1   2  0  0
random_tail    100  1   6  0  0
